// File: core_pkg.sv
/* rv32 core shared types */

package core_pkg;

	localparam int XLEN = 32;

	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_idx_t;

	// major opcodes kept by this core
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_or,
		alu_and,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b	// lui
	} alu_op_e;

	// same coding as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		mem_byte = 2'b00,
		mem_half = 2'b01,
		mem_word = 2'b10
	} mem_size_e;

	typedef struct packed {
		alu_op_e         alu_op;
		logic [XLEN-1:0] src1;
		logic [XLEN-1:0] src2;		// register or immediate
		logic [XLEN-1:0] store_data;
		reg_idx_t        rd;
		logic            wr_en;
		logic            load;
		logic            store;
		mem_size_e       mem_size;
		logic            mem_unsigned;
	} ex_ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0] result;	// alu result or address
		logic [XLEN-1:0] store_data;
		reg_idx_t        rd;
		logic            wr_en;
		logic            load;
		logic            store;
		mem_size_e       mem_size;
		logic            mem_unsigned;
	} mem_ctrl_t;

	typedef struct packed {
		logic            rd0_wr1;
		logic [3:0]      byte_strobe;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] write_data;
	} dmem_req_t;

	typedef struct packed {
		logic            valid;
		reg_idx_t        rd;
		logic [XLEN-1:0] data;
	} wb_t;

endpackage

// File: stage_reg.sv
/* pipeline stage register */

`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     cpu_clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	// free slot, or the held entry leaves this cycle
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;	// payload only
		end
	end

endmodule

// File: fetch.sv
/* instruction fetch */

`timescale 1ns/1ps

module fetch import core_pkg::*; (
	input  logic            cpu_clk,
	input  logic            rst_n,
	input  logic [XLEN-1:0] boot_addr,
	output logic            instr_access,
	output logic [XLEN-1:0] instr_addr,
	input  instr_t          instr_read_data,
	input  logic            instr_read_data_valid,
	output logic            if_valid,
	input  logic            dec_ready,
	output instr_t          instr_dec,
	input  logic            retire
);

	typedef enum logic [2:0] {
		st_idle,	// one cycle out of reset
		st_req,		// request pulse
		st_wait,	// waiting for instruction data
		st_hold,	// instruction offered to decode
		st_exec		// in flight until retire
	} fetch_st_e;

	fetch_st_e       state;
	logic [XLEN-1:0] pc;

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			state <= st_idle;
			pc    <= boot_addr;
		end else begin
			case (state)
				st_idle: state <= st_req;
				st_req:  state <= st_wait;
				st_wait: begin
					if (instr_read_data_valid) begin
						state <= st_hold;
					end
				end
				st_hold: begin
					if (dec_ready) begin
						state <= st_exec;
					end
				end
				st_exec: begin
					// no branches, always the next word
					if (retire) begin
						state <= st_req;
						pc    <= pc + XLEN'(4);
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (state == st_wait && instr_read_data_valid) begin
			instr_dec <= instr_read_data;
		end
	end

	assign instr_access = (state == st_req);
	assign instr_addr   = pc;
	assign if_valid     = (state == st_hold);

endmodule

// File: dec.sv
/* decoder and register file */

`timescale 1ns/1ps

module dec import core_pkg::*; #(
	parameter int REG_NUM = 32
) (
	input  logic     cpu_clk,
	input  logic     rst_n,
	input  logic     if_valid,
	output logic     dec_ready,
	input  instr_t   instr_dec,
	output logic     dec_valid,
	input  logic     ex_ready,
	output ex_ctrl_t ex_ctrl,
	input  wb_t      wb
);

	localparam int IDX_W = $clog2(REG_NUM);

	logic [XLEN-1:0] regs [REG_NUM];
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	reg_idx_t        rs1, rs2, rd;
	logic [XLEN-1:0] imm_i, imm_s, imm_u;
	logic [XLEN-1:0] rs1_data, rs2_data;
	logic            is_op, f7_zero, f7_alt;
	logic            legal, use_rs1, use_rs2, regs_ok;
	mem_size_e       size_c;

	assign opcode = instr_dec[6:0];
	assign rd     = instr_dec[11:7];
	assign funct3 = instr_dec[14:12];
	assign rs1    = instr_dec[19:15];
	assign rs2    = instr_dec[24:20];
	assign funct7 = instr_dec[31:25];

	assign imm_i = {{20{instr_dec[31]}}, instr_dec[31:20]};
	assign imm_s = {{20{instr_dec[31]}}, instr_dec[31:25], instr_dec[11:7]};
	assign imm_u = {instr_dec[31:12], 12'b0};

	assign is_op   = (opcode == OPC_OP);
	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);	// sub, sra
	assign size_c  = (funct3[1:0] == 2'b00) ? mem_byte : (funct3[0] ? mem_half : mem_word);

	// x0 and registers beyond REG_NUM read as zero
	assign rs1_data = (rs1 == '0 || int'(rs1) >= REG_NUM) ? '0 : regs[rs1[IDX_W-1:0]];
	assign rs2_data = (rs2 == '0 || int'(rs2) >= REG_NUM) ? '0 : regs[rs2[IDX_W-1:0]];

	always_comb begin
		legal   = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		ex_ctrl = '0;
		ex_ctrl.alu_op       = alu_add;
		ex_ctrl.src1         = rs1_data;
		ex_ctrl.src2         = imm_i;
		ex_ctrl.store_data   = rs2_data;
		ex_ctrl.rd           = rd;
		ex_ctrl.mem_size     = size_c;
		ex_ctrl.mem_unsigned = funct3[2];
		case (opcode)
			OPC_LUI: begin
				legal          = 1'b1;
				ex_ctrl.alu_op = alu_pass_b;
				ex_ctrl.src2   = imm_u;
				ex_ctrl.wr_en  = 1'b1;
			end
			OPC_OP_IMM, OPC_OP: begin
				use_rs1       = 1'b1;
				use_rs2       = is_op;
				ex_ctrl.wr_en = 1'b1;
				if (is_op) begin
					ex_ctrl.src2 = rs2_data;
				end
				// funct7 only matters for register ops and shifts
				legal = !is_op || f7_zero;
				case (funct3)
					3'b000: begin
						ex_ctrl.alu_op = (is_op && f7_alt) ? alu_sub : alu_add;
						legal          = !is_op || f7_zero || f7_alt;
					end
					3'b001: begin
						ex_ctrl.alu_op = alu_sll;
						legal          = f7_zero;
					end
					3'b010: ex_ctrl.alu_op = alu_slt;
					3'b011: ex_ctrl.alu_op = alu_sltu;
					3'b100: ex_ctrl.alu_op = alu_xor;
					3'b101: begin
						ex_ctrl.alu_op = f7_alt ? alu_sra : alu_srl;
						legal          = f7_zero || f7_alt;
					end
					3'b110: ex_ctrl.alu_op = alu_or;
					default: ex_ctrl.alu_op = alu_and;
				endcase
			end
			OPC_LOAD: begin
				use_rs1       = 1'b1;
				legal         = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
				ex_ctrl.load  = 1'b1;
				ex_ctrl.wr_en = 1'b1;
			end
			OPC_STORE: begin
				use_rs1       = 1'b1;
				use_rs2       = 1'b1;
				legal         = funct3 inside {3'b000, 3'b001, 3'b010};
				ex_ctrl.store = 1'b1;
				ex_ctrl.src2  = imm_s;
			end
			default: legal = 1'b0;
		endcase
		regs_ok = (!use_rs1 || int'(rs1) < REG_NUM) && (!use_rs2 || int'(rs2) < REG_NUM)
			&& (!ex_ctrl.wr_en || int'(rd) < REG_NUM);
		if (!(legal && regs_ok)) begin
			ex_ctrl.wr_en = 1'b0;	// retires as a no-op
			ex_ctrl.load  = 1'b0;
			ex_ctrl.store = 1'b0;
		end
	end

	assign dec_valid = if_valid;
	assign dec_ready = ex_ready;

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && wb.rd != '0 && int'(wb.rd) < REG_NUM) begin
			regs[wb.rd[IDX_W-1:0]] <= wb.data;
		end
	end

endmodule

// File: alu.sv
/* execute stage */

`timescale 1ns/1ps

module alu import core_pkg::*; (
	input  logic      ex_valid_in,
	input  ex_ctrl_t  ex_ctrl,
	output logic      ex_ready_out,
	output logic      mem_valid,
	input  logic      mem_ready,
	output mem_ctrl_t mem_ctrl
);

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] alu_res;
	logic [4:0]      shamt;

	assign shamt = ex_ctrl.src2[4:0];
	assign sum   = ex_ctrl.src1 + ex_ctrl.src2;	// also the memory address

	always_comb begin
		case (ex_ctrl.alu_op)
			alu_add:    alu_res = sum;
			alu_sub:    alu_res = ex_ctrl.src1 - ex_ctrl.src2;
			alu_slt: begin
				alu_res = {31'b0, $signed(ex_ctrl.src1) < $signed(ex_ctrl.src2)};
			end
			alu_sltu:   alu_res = {31'b0, ex_ctrl.src1 < ex_ctrl.src2};
			alu_xor:    alu_res = ex_ctrl.src1 ^ ex_ctrl.src2;
			alu_or:     alu_res = ex_ctrl.src1 | ex_ctrl.src2;
			alu_and:    alu_res = ex_ctrl.src1 & ex_ctrl.src2;
			alu_sll:    alu_res = ex_ctrl.src1 << shamt;
			alu_srl:    alu_res = ex_ctrl.src1 >> shamt;
			alu_sra:    alu_res = $unsigned($signed(ex_ctrl.src1) >>> shamt);
			alu_pass_b: alu_res = ex_ctrl.src2;
			default:    alu_res = sum;
		endcase
	end

	always_comb begin
		mem_ctrl = '0;
		// loads and stores decode to add, so this is their address
		mem_ctrl.result       = alu_res;
		mem_ctrl.store_data   = ex_ctrl.store_data;
		mem_ctrl.rd           = ex_ctrl.rd;
		mem_ctrl.wr_en        = ex_ctrl.wr_en;
		mem_ctrl.load         = ex_ctrl.load;
		mem_ctrl.store        = ex_ctrl.store;
		mem_ctrl.mem_size     = ex_ctrl.mem_size;
		mem_ctrl.mem_unsigned = ex_ctrl.mem_unsigned;
	end

	assign mem_valid    = ex_valid_in;
	assign ex_ready_out = mem_ready;

endmodule

// File: dmem_ctrl.sv
/* data port and write-back */

`timescale 1ns/1ps

module dmem_ctrl import core_pkg::*; (
	input  logic            cpu_clk,
	input  logic            rst_n,
	input  logic            mem_valid,
	output logic            mem_ready,
	input  mem_ctrl_t       mem_ctrl,
	output logic            data_access,
	input  logic            data_ready,
	output dmem_req_t       data_req,
	input  logic [XLEN-1:0] data_read_data,
	input  logic            data_read_data_valid,
	output wb_t             wb,
	output logic            retire
);

	typedef enum logic {st_idle, st_rdata} dmem_st_e;

	dmem_st_e        state;
	logic            mem_op, req_accept;
	logic            alu_done, store_done, load_done;
	logic [7:0]      load_byte;
	logic [15:0]     load_half;
	logic [XLEN-1:0] load_data;

	assign mem_op      = mem_ctrl.load || mem_ctrl.store;
	assign data_access = (state == st_idle) && mem_valid && mem_op;
	assign req_accept  = data_access && data_ready;

	always_comb begin
		data_req         = '0;
		data_req.rd0_wr1 = mem_ctrl.store;
		data_req.addr    = mem_ctrl.result;
		case (mem_ctrl.mem_size)
			mem_byte: begin
				data_req.byte_strobe = 4'b0001 << mem_ctrl.result[1:0];
				data_req.write_data  = {4{mem_ctrl.store_data[7:0]}};
			end
			mem_half: begin
				data_req.byte_strobe = mem_ctrl.result[1] ? 4'b1100 : 4'b0011;
				data_req.write_data  = {2{mem_ctrl.store_data[15:0]}};
			end
			default: begin
				data_req.byte_strobe = 4'b1111;
				data_req.write_data  = mem_ctrl.store_data;
			end
		endcase
	end

	// lane pick for loads
	assign load_byte = data_read_data[{mem_ctrl.result[1:0], 3'b000} +: 8];
	assign load_half = mem_ctrl.result[1] ? data_read_data[31:16] : data_read_data[15:0];

	always_comb begin
		case (mem_ctrl.mem_size)
			mem_byte: load_data = mem_ctrl.mem_unsigned ? {24'b0, load_byte}
				: {{24{load_byte[7]}}, load_byte};
			mem_half: load_data = mem_ctrl.mem_unsigned ? {16'b0, load_half}
				: {{16{load_half[15]}}, load_half};
			default:  load_data = data_read_data;
		endcase
	end

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else if (state == st_idle && req_accept && mem_ctrl.load) begin
			state <= st_rdata;
		end else if (state == st_rdata && data_read_data_valid) begin
			state <= st_idle;
		end
	end

	assign alu_done   = (state == st_idle) && mem_valid && !mem_op;
	assign store_done = req_accept && mem_ctrl.store;	// writes finish on accept
	assign load_done  = (state == st_rdata) && data_read_data_valid;

	assign retire    = alu_done || store_done || load_done;
	assign mem_ready = retire;	// slot held until the instruction completes

	always_comb begin
		wb       = '0;
		wb.valid = (alu_done || load_done) && mem_ctrl.wr_en;
		wb.rd    = mem_ctrl.rd;
		wb.data  = load_done ? load_data : mem_ctrl.result;
	end

endmodule

// File: core.sv
/* rv32 core top */

`timescale 1ns/1ps

module core import core_pkg::*; #(
	parameter int REG_NUM = 32	// 16 for rv32e
) (
	input  logic            cpu_clk,
	input  logic            rst_n,
	input  logic [XLEN-1:0] boot_addr,
	output logic            instr_access,
	output logic [XLEN-1:0] instr_addr,
	input  instr_t          instr_read_data,
	input  logic            instr_read_data_valid,
	output logic            data_access,
	input  logic            data_ready,
	output dmem_req_t       data_req,
	input  logic [XLEN-1:0] data_read_data,
	input  logic            data_read_data_valid
);

	logic      if_valid, dec_ready, dec_valid, ex_ready;
	logic      ex_valid, alu_ready, alu_valid, mem_reg_ready;
	logic      mem_valid, mem_ready, retire;
	instr_t    instr_dec;
	ex_ctrl_t  dec_ctrl, ex_ctrl;
	mem_ctrl_t alu_ctrl, mem_ctrl;
	wb_t       wb;

	fetch u_fetch (
		.cpu_clk(cpu_clk), .rst_n(rst_n), .boot_addr(boot_addr),
		.instr_access(instr_access), .instr_addr(instr_addr),
		.instr_read_data(instr_read_data), .instr_read_data_valid(instr_read_data_valid),
		.if_valid(if_valid), .dec_ready(dec_ready), .instr_dec(instr_dec), .retire(retire)
	);

	dec #(.REG_NUM(REG_NUM)) u_dec (
		.cpu_clk(cpu_clk), .rst_n(rst_n), .if_valid(if_valid), .dec_ready(dec_ready),
		.instr_dec(instr_dec), .dec_valid(dec_valid), .ex_ready(ex_ready),
		.ex_ctrl(dec_ctrl), .wb(wb)
	);

	stage_reg #(.payload_t(ex_ctrl_t)) u_ex_reg (
		.cpu_clk(cpu_clk), .rst_n(rst_n), .in_valid(dec_valid), .in_ready(ex_ready),
		.in_data(dec_ctrl), .out_valid(ex_valid), .out_ready(alu_ready), .out_data(ex_ctrl)
	);

	alu u_alu (
		.ex_valid_in(ex_valid), .ex_ctrl(ex_ctrl), .ex_ready_out(alu_ready),
		.mem_valid(alu_valid), .mem_ready(mem_reg_ready), .mem_ctrl(alu_ctrl)
	);

	stage_reg #(.payload_t(mem_ctrl_t)) u_mem_reg (
		.cpu_clk(cpu_clk), .rst_n(rst_n), .in_valid(alu_valid), .in_ready(mem_reg_ready),
		.in_data(alu_ctrl), .out_valid(mem_valid), .out_ready(mem_ready), .out_data(mem_ctrl)
	);

	dmem_ctrl u_dmem_ctrl (
		.cpu_clk(cpu_clk), .rst_n(rst_n), .mem_valid(mem_valid), .mem_ready(mem_ready),
		.mem_ctrl(mem_ctrl), .data_access(data_access), .data_ready(data_ready),
		.data_req(data_req), .data_read_data(data_read_data),
		.data_read_data_valid(data_read_data_valid), .wb(wb), .retire(retire)
	);

endmodule

// File: core_sva.sv
/* port protocol assertions */

`timescale 1ns/1ps

module core_sva import core_pkg::*; (
	input logic      cpu_clk,
	input logic      rst_n,
	input logic      instr_access,
	input logic      instr_read_data_valid,
	input logic      data_access,
	input logic      data_ready,
	input dmem_req_t data_req
);

	logic instr_pending;	// request out, data not back yet

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			instr_pending <= 1'b0;
		end else if (instr_access) begin
			instr_pending <= 1'b1;
		end else if (instr_read_data_valid) begin
			instr_pending <= 1'b0;
		end
	end

	data_req_stable: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		data_access && !data_ready |=> data_access && $stable(data_req))
		else $error("data request dropped or changed while data_ready was low");

	instr_access_pulse: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		instr_access |=> !instr_access)
		else $error("instr_access stayed high for more than one cycle");

	instr_one_pending: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		instr_pending |-> !instr_access)
		else $error("new instruction request before the previous data returned");

endmodule

bind core core_sva u_core_sva (.*);

// File: core_tb.sv
/* rv32 core testbench */

`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

	localparam logic [31:0] BOOT = 32'h0000_1000;
	localparam logic [31:0] A    = 32'h8765_4321;	// x2
	localparam logic [31:0] N    = 32'hffff_fffb;	// x3 holds -5
	localparam logic [31:0] S    = 32'h0000_0007;	// x4
	localparam instr_t      NOP  = 32'h0000_0013;
	localparam reg_idx_t    X0   = 5'd0;
	localparam reg_idx_t    X1   = 5'd1;
	localparam reg_idx_t    X2   = 5'd2;
	localparam reg_idx_t    X3   = 5'd3;
	localparam reg_idx_t    X4   = 5'd4;
	localparam reg_idx_t    X5   = 5'd5;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  strobe;
		logic [31:0] data;
	} st_exp_t;

	logic            cpu_clk;
	logic            rst_n = 1'b0;
	logic [XLEN-1:0] boot_addr = BOOT;
	logic            instr_access;
	logic [XLEN-1:0] instr_addr;
	instr_t          instr_read_data = '0;
	logic            instr_read_data_valid = 1'b0;
	logic            data_access;
	logic            data_ready = 1'b0;
	dmem_req_t       data_req;
	logic [XLEN-1:0] data_read_data = '0;
	logic            data_read_data_valid = 1'b0;

	instr_t      prog_q[$];
	st_exp_t     exp_q[$];
	string       name_q[$];
	logic [11:0] st_off = 12'h000;	// next slot of the result area
	integer      seed = 32'hed13ab14;
	int          fetch_errors = 0;
	int          store_errors = 0;

	logic [31:0] exp_pc;
	int          i_index;
	logic        i_pending;
	logic        d_pending;
	logic [1:0]  i_wait;
	logic [1:0]  d_wait;
	logic [1:0]  stall_run;
	logic [7:0]  d_index;
	logic [31:0] dmem [256];

	core #(.REG_NUM(32)) dut (.*);

	initial begin
		cpu_clk = 1'b0;
		forever #4 cpu_clk = ~cpu_clk;
	end

	// instruction encoders
	function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
			input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic instr_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic instr_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
		return {imm, rd, OPC_LUI};
	endfunction

	function automatic instr_t fetch_word(input int idx);
		if (idx >= 0 && idx < prog_q.size()) begin
			return prog_q[idx];
		end
		return NOP;	// past the end of the program
	endfunction

	task automatic emit_instr(input instr_t word);
		prog_q.push_back(word);
	endtask

	task automatic expect_store(input string name, input instr_t word, input logic [31:0] addr,
			input logic [3:0] strobe, input logic [31:0] data);
		prog_q.push_back(word);
		name_q.push_back(name);
		exp_q.push_back({addr, strobe, data});
	endtask

	// op leaves its result in x5 and sw x5 puts it in the result area
	task automatic expect_word(input string name, input instr_t op, input logic [31:0] value);
		emit_instr(op);
		expect_store(name, enc_s(st_off, X5, X1, 3'b010), 32'h100 + {20'b0, st_off}, 4'hf, value);
		st_off = st_off + 12'h004;
	endtask

	task automatic build_program();
		emit_instr(enc_i(12'h100, X0, 3'b000, X1, OPC_OP_IMM));	// base 0x100
		emit_instr(enc_u(20'h87654, X2));
		emit_instr(enc_i(12'h321, X2, 3'b000, X2, OPC_OP_IMM));
		emit_instr(enc_i(12'hffb, X0, 3'b000, X3, OPC_OP_IMM));
		emit_instr(enc_i(12'h007, X0, 3'b000, X4, OPC_OP_IMM));
		expect_word("lui_addi", enc_i(12'h000, X2, 3'b000, X5, OPC_OP_IMM), A);
		expect_word("add", enc_r(7'h00, X4, X2, 3'b000, X5), A + S);
		expect_word("sub", enc_r(7'h20, X3, X4, 3'b000, X5), S - N);
		expect_word("slt", enc_r(7'h00, X4, X3, 3'b010, X5), 32'd1);	// -5 < 7
		expect_word("sltu", enc_r(7'h00, X4, X3, 3'b011, X5), 32'd0);
		expect_word("xor", enc_r(7'h00, X3, X2, 3'b100, X5), A ^ N);
		expect_word("or", enc_r(7'h00, X3, X2, 3'b110, X5), A | N);
		expect_word("and", enc_r(7'h00, X3, X2, 3'b111, X5), A & N);
		expect_word("sll", enc_r(7'h00, X4, X2, 3'b001, X5), A << 7);
		expect_word("srl", enc_r(7'h00, X4, X2, 3'b101, X5), A >> 7);
		expect_word("sra", enc_r(7'h20, X4, X2, 3'b101, X5), 32'hff0e_ca86);	// sign fills 7 bits
		expect_word("addi", enc_i(12'h064, X3, 3'b000, X5, OPC_OP_IMM), N + 32'd100);
		expect_word("slti", enc_i(12'hffc, X3, 3'b010, X5, OPC_OP_IMM), 32'd1);	// -5 < -4
		expect_word("sltiu", enc_i(12'hfff, X4, 3'b011, X5, OPC_OP_IMM), 32'd1);
		expect_word("xori", enc_i(12'hfff, X2, 3'b100, X5, OPC_OP_IMM), A ^ 32'hffff_ffff);
		expect_word("ori", enc_i(12'h7f0, X4, 3'b110, X5, OPC_OP_IMM), S | 32'h0000_07f0);
		expect_word("andi", enc_i(12'h0ff, X2, 3'b111, X5, OPC_OP_IMM), A & 32'h0000_00ff);
		expect_word("slli", enc_i(12'h01c, X4, 3'b001, X5, OPC_OP_IMM), S << 28);
		expect_word("srli", enc_i(12'h00c, X2, 3'b101, X5, OPC_OP_IMM), A >> 12);
		expect_word("srai", enc_i(12'h40c, X2, 3'b101, X5, OPC_OP_IMM), 32'hfff8_7654);
		// sub-word stores with one lane per addr[1:0] and replicated data
		expect_store("sb_lane0", enc_s(12'h080, X2, X1, 3'b000), 32'h180, 4'b0001, {4{A[7:0]}});
		expect_store("sb_lane1", enc_s(12'h081, X2, X1, 3'b000), 32'h181, 4'b0010, {4{A[7:0]}});
		expect_store("sb_lane3", enc_s(12'h083, X2, X1, 3'b000), 32'h183, 4'b1000, {4{A[7:0]}});
		expect_store("sh_low", enc_s(12'h084, X2, X1, 3'b001), 32'h184, 4'b0011, {2{A[15:0]}});
		expect_store("sh_high", enc_s(12'h086, X2, X1, 3'b001), 32'h186, 4'b1100, {2{A[15:0]}});
		// load source word at 0x190
		expect_store("sw_src", enc_s(12'h090, X2, X1, 3'b010), 32'h190, 4'hf, A);
		expect_word("lb_lane3", enc_i(12'h093, X1, 3'b000, X5, OPC_LOAD), {{24{A[31]}}, A[31:24]});
		expect_word("lbu_lane3", enc_i(12'h093, X1, 3'b100, X5, OPC_LOAD), {24'b0, A[31:24]});
		expect_word("lb_lane0", enc_i(12'h090, X1, 3'b000, X5, OPC_LOAD), {{24{A[7]}}, A[7:0]});
		expect_word("lbu_lane1", enc_i(12'h091, X1, 3'b100, X5, OPC_LOAD), {24'b0, A[15:8]});
		expect_word("lh_high", enc_i(12'h092, X1, 3'b001, X5, OPC_LOAD), {{16{A[31]}}, A[31:16]});
		expect_word("lhu_high", enc_i(12'h092, X1, 3'b101, X5, OPC_LOAD), {16'b0, A[31:16]});
		expect_word("lh_low", enc_i(12'h090, X1, 3'b001, X5, OPC_LOAD), {{16{A[15]}}, A[15:0]});
		expect_word("lw", enc_i(12'h090, X1, 3'b010, X5, OPC_LOAD), A);
		// x0 keeps reading zero after writes
		emit_instr(enc_i(12'h055, X0, 3'b000, X0, OPC_OP_IMM));
		emit_instr(enc_u(20'hfffff, X0));
		expect_word("x0_discard", enc_i(12'h000, X0, 3'b000, X5, OPC_OP_IMM), 32'h0);
		// unsupported words all name x5 in the rd field and must leave it alone
		emit_instr(enc_i(12'h055, X0, 3'b000, X5, OPC_OP_IMM));
		emit_instr(32'hffff_f2ff);	// opcode 7f
		emit_instr(32'h0052_82e3);	// branch
		expect_word("illegal_keep", enc_r(7'h01, X4, X2, 3'b000, X5), 32'h0000_0055);
	endtask

	// instruction and data memory models
	always @(posedge cpu_clk) begin
		instr_read_data_valid <= 1'b0;
		data_read_data_valid  <= 1'b0;
		if (!rst_n) begin
			exp_pc     <= BOOT;
			i_pending  <= 1'b0;
			d_pending  <= 1'b0;
			data_ready <= 1'b0;
			stall_run  <= 2'd0;
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= 32'hc3a5_0000 | 32'(i << 2);	// byte address in the low bits
			end
		end else begin
			if (i_pending) begin
				if (i_wait == 2'd0) begin
					instr_read_data_valid <= 1'b1;
					instr_read_data       <= fetch_word(i_index);
					i_pending             <= 1'b0;
				end else begin
					i_wait <= i_wait - 2'd1;
				end
			end
			if (instr_access) begin
				assert (instr_addr == exp_pc) else begin
					$display("Error: fetch_addr expected %h actual %h", exp_pc, instr_addr);
					fetch_errors++;
				end
				exp_pc    <= exp_pc + 32'd4;
				i_index   <= int'((instr_addr - BOOT) >> 2);
				i_wait    <= 2'($unsigned($random(seed)) % 3);
				i_pending <= 1'b1;
			end
			if (d_pending) begin
				if (d_wait == 2'd0) begin
					data_read_data_valid <= 1'b1;
					data_read_data       <= dmem[d_index];
					d_pending            <= 1'b0;
				end else begin
					d_wait <= d_wait - 2'd1;
				end
			end
			if (data_access && data_ready) begin
				if (data_req.rd0_wr1) begin
					for (int b = 0; b < 4; b++) begin
						if (data_req.byte_strobe[b]) begin
							dmem[data_req.addr[9:2]][8*b +: 8] <= data_req.write_data[8*b +: 8];
						end
					end
				end else begin
					d_index   <= data_req.addr[9:2];
					d_wait    <= 2'($unsigned($random(seed)) % 3);
					d_pending <= 1'b1;
				end
			end
			// ready low about one cycle in four and never more than two in a row
			if (stall_run < 2'd2 && ($random(seed) & 3) == 0) begin
				data_ready <= 1'b0;
				stall_run  <= stall_run + 2'd1;
			end else begin
				data_ready <= 1'b1;
				stall_run  <= 2'd0;
			end
		end
	end

	initial begin
		st_exp_t seen;
		build_program();
		repeat (2) @(posedge cpu_clk);
		rst_n <= 1'b1;
		// accepted writes, in program order
		for (int k = 0; k < exp_q.size(); k++) begin
			@(posedge cpu_clk);
			while (!(data_access && data_ready && data_req.rd0_wr1)) begin
				@(posedge cpu_clk);
			end
			seen = {data_req.addr, data_req.byte_strobe, data_req.write_data};
			assert (seen == exp_q[k]) else begin
				$display("Error: %s expected addr %h strobe %b data %h actual addr %h strobe %b data %h",
					name_q[k], exp_q[k].addr, exp_q[k].strobe, exp_q[k].data,
					seen.addr, seen.strobe, seen.data);
				store_errors++;
			end
		end
		repeat (4) @(posedge cpu_clk);
		$display("fetch errors: %0d, store errors: %0d", fetch_errors, store_errors);
		if (fetch_errors + store_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		int limit;
		int cycles;
		@(posedge cpu_clk);
		limit  = prog_q.size() * 16 + 50;	// per instruction budget
		cycles = 0;
		while (cycles < limit) begin
			@(posedge cpu_clk);
			cycles++;
		end
		$display("Timeout: not all %0d stores were seen within %0d cycles", exp_q.size(), limit);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: verilog.f
core_pkg.sv
stage_reg.sv
fetch.sv
dec.sv
alu.sv
dmem_ctrl.sv
core.sv
core_sva.sv
core_tb.sv

// File: Makefile
.PHONY: all run clean

all: run

obj_dir/Vcore_tb: verilog.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 --top-module core_tb -f verilog.f

run: obj_dir/Vcore_tb
	@out="$$(./obj_dir/Vcore_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
